//--- cache/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cpu_valid,
    input  cpu_req_t              cpu_req,
    output logic                  cpu_done,
    output word_t                 cpu_rdata,
    output mem_req_t              mem_req,
    input  line_t                 mem_rline,
    input  logic                  mem_ready,
    input  logic                  mem_ack,
    input  tag_entry_t            tag_rd0,
    input  tag_entry_t            tag_rd1,
    input  line_t                 line_rd0,
    input  line_t                 line_rd1,
    input  logic                  hit,
    input  logic                  hit_way,
    input  logic                  victim_way,
    input  tag_entry_t            touch0,
    input  tag_entry_t            touch1,
    input  word_t                 sel_word,
    input  line_t                 merged_line,
    output line_t                 merge_src,
    output logic [index_bits-1:0] index,
    output logic                  tag_we0,
    output logic                  tag_we1,
    output logic                  data_we0,
    output logic                  data_we1,
    output tag_entry_t            tag_wr0,
    output tag_entry_t            tag_wr1,
    output line_t                 line_wr
);

    ctrl_state_t state_q;
    ctrl_state_t state_d;
    mem_req_t    mem_req_q;
    mem_req_t    mem_req_d;
    logic        victim_q;
    logic        victim_d;

    cpu_addr_t   req_addr;
    logic        req_active;
    tag_entry_t  victim_tag;
    line_t       victim_line;
    word_t       fill_addr;
    word_t       victim_addr;
    tag_entry_t  fill_entry;

    assign req_addr   = cpu_req.addr;
    assign index      = req_addr.index;
    assign req_active = cpu_valid && (cpu_req.read || cpu_req.write);

    assign victim_tag  = victim_way ? tag_rd1 : tag_rd0;
    assign victim_line = victim_way ? line_rd1 : line_rd0;

    // line addresses for the refill and for the evicted line
    assign fill_addr   = {req_addr.tag, req_addr.index, {offset_bits{1'b0}}};
    assign victim_addr = {victim_tag.tag, req_addr.index, {offset_bits{1'b0}}};

    // the merge works on the hit line, or on the refill while allocating
    assign merge_src = (state_q == allocate) ? mem_rline : (hit_way ? line_rd1 : line_rd0);

    // hits answer in the cycle the request is seen
    assign cpu_done  = (state_q == check) && req_active && hit;
    assign cpu_rdata = sel_word;
    assign mem_req   = mem_req_q;

    // new entry for the victim way after a refill
    always_comb begin
        fill_entry        = '0;
        fill_entry.valid  = 1'b1;
        fill_entry.dirty  = cpu_req.write;
        fill_entry.recent = 1'b1;
        fill_entry.tag    = req_addr.tag;
    end

    // array write control
    always_comb begin
        tag_we0  = 1'b0;
        tag_we1  = 1'b0;
        data_we0 = 1'b0;
        data_we1 = 1'b0;
        tag_wr0  = touch0;
        tag_wr1  = touch1;
        line_wr  = merged_line;

        case (state_q)
            check: begin
                if (req_active && hit) begin
                    // recent bits move to the hit way on every hit
                    tag_we0 = 1'b1;
                    tag_we1 = 1'b1;
                    if (cpu_req.write) begin
                        if (hit_way) begin
                            tag_wr1.dirty = 1'b1;
                            data_we1      = 1'b1;
                        end else begin
                            tag_wr0.dirty = 1'b1;
                            data_we0      = 1'b1;
                        end
                    end
                end
            end
            allocate: begin
                if (mem_ready) begin
                    tag_we0 = 1'b1;
                    tag_we1 = 1'b1;
                    line_wr = cpu_req.write ? merged_line : mem_rline;
                    // the other way keeps its entry with recent cleared
                    if (victim_q) begin
                        tag_wr1  = fill_entry;
                        data_we1 = 1'b1;
                    end else begin
                        tag_wr0  = fill_entry;
                        data_we0 = 1'b1;
                    end
                end
            end
            default: begin
            end
        endcase
    end

    // next state and memory request
    always_comb begin
        state_d   = state_q;
        mem_req_d = mem_req_q;
        victim_d  = victim_q;

        case (state_q)
            check: begin
                if (req_active && !hit) begin
                    victim_d = victim_way;
                    if (victim_tag.valid && victim_tag.dirty) begin
                        mem_req_d.write = 1'b1;
                        mem_req_d.addr  = victim_addr;
                        mem_req_d.wline = victim_line;
                        state_d         = write_back;
                    end else begin
                        mem_req_d.read = 1'b1;
                        mem_req_d.addr = fill_addr;
                        state_d        = allocate;
                    end
                end
            end
            write_back: begin
                // victim is out, go fetch the requested line
                if (mem_ack) begin
                    mem_req_d.write = 1'b0;
                    mem_req_d.read  = 1'b1;
                    mem_req_d.addr  = fill_addr;
                    state_d         = allocate;
                end
            end
            allocate: begin
                // refill lands in the arrays, then check again
                if (mem_ready) begin
                    mem_req_d.read = 1'b0;
                    state_d        = check;
                end
            end
            default: begin
                state_d = check;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state_q         <= check;
            mem_req_q.read  <= 1'b0;
            mem_req_q.write <= 1'b0;
        end else begin
            state_q   <= state_d;
            mem_req_q <= mem_req_d;
        end
    end

    always_ff @(posedge clk) begin
        victim_q <= victim_d;
    end

endmodule

//--- cache/cache_top.sv
`timescale 1ns/1ps

module cache_top import cache_pkg::*; #(
    parameter int  set_count = cache_pkg::set_count,
    parameter type tag_t     = tag_entry_t,
    parameter type data_t    = line_t
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     cpu_valid,
    input  cpu_req_t cpu_req,
    output logic     cpu_done,
    output word_t    cpu_rdata,
    output mem_req_t mem_req,
    input  line_t    mem_rline,
    input  logic     mem_ready,
    input  logic     mem_ack
);

    // array read side
    tag_t  tag_rd0;
    tag_t  tag_rd1;
    data_t line_rd0;
    data_t line_rd1;

    // array write side
    logic [index_bits-1:0] index;
    logic                  tag_we0;
    logic                  tag_we1;
    logic                  data_we0;
    logic                  data_we1;
    tag_t                  tag_wr0;
    tag_t                  tag_wr1;
    data_t                 line_wr;

    // lookup and merge results
    logic       hit;
    logic       hit_way;
    logic       victim_way;
    tag_t       touch0;
    tag_t       touch1;
    word_t      sel_word;
    data_t      merge_src;
    data_t      merged_line;

    cache_ctrl u_cache_ctrl (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .mem_req     (mem_req),
        .mem_rline   (mem_rline),
        .mem_ready   (mem_ready),
        .mem_ack     (mem_ack),
        .tag_rd0     (tag_rd0),
        .tag_rd1     (tag_rd1),
        .line_rd0    (line_rd0),
        .line_rd1    (line_rd1),
        .hit         (hit),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .touch0      (touch0),
        .touch1      (touch1),
        .sel_word    (sel_word),
        .merged_line (merged_line),
        .merge_src   (merge_src),
        .index       (index),
        .tag_we0     (tag_we0),
        .tag_we1     (tag_we1),
        .data_we0    (data_we0),
        .data_we1    (data_we1),
        .tag_wr0     (tag_wr0),
        .tag_wr1     (tag_wr1),
        .line_wr     (line_wr)
    );

    way_select u_way_select (
        .req_addr   (cpu_req.addr),
        .tag_rd0    (tag_rd0),
        .tag_rd1    (tag_rd1),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .touch0     (touch0),
        .touch1     (touch1)
    );

    line_merge u_line_merge (
        .line_in  (merge_src),
        .offset   (cpu_req.addr[offset_bits-1:0]),
        .word_in  (cpu_req.wdata),
        .word_out (sel_word),
        .line_out (merged_line)
    );

    way_array #(.entry_t(tag_t), .depth(set_count)) u_tag_way0 (
        .clk     (clk),
        .reset_n (reset_n),
        .index   (index),
        .we      (tag_we0),
        .wdata   (tag_wr0),
        .rdata   (tag_rd0)
    );

    way_array #(.entry_t(tag_t), .depth(set_count)) u_tag_way1 (
        .clk     (clk),
        .reset_n (reset_n),
        .index   (index),
        .we      (tag_we1),
        .wdata   (tag_wr1),
        .rdata   (tag_rd1)
    );

    // both data ways share the line write bus
    way_array #(.entry_t(data_t), .depth(set_count)) u_data_way0 (
        .clk     (clk),
        .reset_n (reset_n),
        .index   (index),
        .we      (data_we0),
        .wdata   (line_wr),
        .rdata   (line_rd0)
    );

    way_array #(.entry_t(data_t), .depth(set_count)) u_data_way1 (
        .clk     (clk),
        .reset_n (reset_n),
        .index   (index),
        .we      (data_we1),
        .wdata   (line_wr),
        .rdata   (line_rd1)
    );

endmodule

//--- common/cache_pkg.sv
package cache_pkg;

    // word and line geometry
    parameter int word_bits   = 16;
    parameter int line_words  = 4;
    parameter int offset_bits = 2;
    parameter int index_bits  = 1;
    parameter int tag_bits    = 13;
    parameter int set_count   = 1 << index_bits;

    typedef logic [word_bits-1:0] word_t;

    // word 0 sits in the low bits of the line
    typedef logic [line_words*word_bits-1:0] line_t;

    // cpu address split: tag | index | block offset
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } cpu_addr_t;

    // one tag entry per way and set
    typedef struct packed {
        logic                valid;
        logic                dirty;
        logic                recent;
        logic [tag_bits-1:0] tag;
    } tag_entry_t;

    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        word_t wdata;
    } cpu_req_t;

    // addr is always line aligned
    typedef struct packed {
        logic  read;
        logic  write;
        word_t addr;
        line_t wline;
    } mem_req_t;

    typedef enum logic [1:0] {
        check,
        allocate,
        write_back
    } ctrl_state_t;

endpackage

//--- logic/line_merge.sv
`timescale 1ns/1ps

module line_merge import cache_pkg::*; (
    input  line_t                  line_in,
    input  logic [offset_bits-1:0] offset,
    input  word_t                  word_in,
    output word_t                  word_out,
    output line_t                  line_out
);

    // line viewed as words, word 0 in the low bits
    word_t [line_words-1:0] words;
    word_t [line_words-1:0] merged;

    assign words = line_in;

    assign word_out = words[offset];

    always_comb begin
        merged         = words;
        merged[offset] = word_in;
    end

    assign line_out = merged;

endmodule

//--- logic/way_array.sv
`timescale 1ns/1ps

module way_array import cache_pkg::*; #(
    parameter type entry_t = line_t,
    parameter int  depth   = set_count
) (
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic [index_bits-1:0] index,
    input  logic                  we,
    input  entry_t                wdata,
    output entry_t                rdata
);

    entry_t mem [depth];

    // read is combinational so hits resolve in the request cycle
    assign rdata = mem[index];

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            // every entry starts out invalid and clean
            for (int i = 0; i < depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[index] <= wdata;
        end
    end

endmodule

//--- logic/way_select.sv
`timescale 1ns/1ps

module way_select import cache_pkg::*; (
    input  word_t      req_addr,
    input  tag_entry_t tag_rd0,
    input  tag_entry_t tag_rd1,
    output logic       hit,
    output logic       hit_way,
    output logic       victim_way,
    output tag_entry_t touch0,
    output tag_entry_t touch1
);

    cpu_addr_t addr;
    logic      hit0;
    logic      hit1;
    logic      chosen;

    assign addr = req_addr;

    assign hit0 = tag_rd0.valid && (tag_rd0.tag == addr.tag);
    assign hit1 = tag_rd1.valid && (tag_rd1.tag == addr.tag);

    assign hit     = hit0 || hit1;
    assign hit_way = hit1 && !hit0;

    // way 0 goes first unless it was the last one used
    assign victim_way = tag_rd0.recent;

    // way that gets touched: the hit way, otherwise the one being refilled
    assign chosen = hit ? hit_way : victim_way;

    always_comb begin
        touch0        = tag_rd0;
        touch1        = tag_rd1;
        touch0.recent = !chosen;
        touch1.recent = chosen;
    end

endmodule

//--- run.sh
#!/bin/sh
# build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_top -Mdir obj_dir -o tb_top_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

//--- tb.f
common/cache_pkg.sv
logic/way_array.sv
logic/way_select.sv
logic/line_merge.sv
cache/cache_ctrl.sv
cache/cache_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import cache_pkg::*; #(
    parameter int run_count      = 2000,
    parameter int readback_count = 48
) (
    input  logic     clk,
    input  logic     reset_n,
    input  logic     cpu_valid,
    input  cpu_req_t cpu_req,
    input  logic     cpu_done,
    input  word_t    cpu_rdata,
    input  mem_req_t mem_req,
    input  line_t    mem_rline,
    input  logic     mem_ready,
    input  logic     mem_ack,
    input  logic     readback,
    input  logic     report,
    output int       error_count
);

    // flat memory image as the cpu sees it
    word_t image [65536];

    // model cache, per set and way
    logic [tag_bits-1:0] m_tag    [set_count][2];
    logic                m_valid  [set_count][2];
    logic                m_dirty  [set_count][2];
    logic                m_recent [set_count][2];
    line_t               m_line   [set_count][2];

    int   checks [1:6] = '{default: 0};
    int   errs   [1:6] = '{default: 0};
    int   reset_edges  = 0;
    int   done_count   = 0;
    logic started      = 1'b0;
    logic reported     = 1'b0;
    logic pend         = 1'b0;

    // the outstanding miss
    cpu_addr_t ra;
    logic      rwrite;
    word_t     rwdata;
    logic      rvictim;
    logic      exp_wb;
    int        wb_seen;
    int        rd_seen;
    word_t     wb_addr;
    word_t     fill_addr;
    line_t     wb_line;

    assign error_count = errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6];

    function automatic string behavior_name(input int b);
        case (b)
            1:       return "quiet after reset";
            2:       return "read data";
            3:       return "hit in first cycle";
            4:       return "clean miss refill";
            5:       return "dirty miss write-back";
            default: return "long run and read-back";
        endcase
    endfunction

    function automatic line_t image_line(input word_t base);
        line_t l;
        for (int i = 0; i < line_words; i++) begin
            l[i*word_bits +: word_bits] = image[base + word_t'(i)];
        end
        return l;
    endfunction

    task automatic value_error(input int b, input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        $display("ERR %s got %h expected %h (behavior %0d, %0t)", name, got, exp, b, $time);
        errs[b]++;
    endtask

    task automatic plain_error(input int b, input string what);
        $display("behavior %0d at %0t: %s", b, $time, what);
        errs[b]++;
    endtask

    task automatic print_result(input int b);
        $display("behavior %0d %s: %0d checks, %0d errors", b, behavior_name(b), checks[b],
                 errs[b]);
    endtask

    // mirrors the reset clear of the arrays and the initial memory pattern
    task automatic clear_model();
        for (int s = 0; s < set_count; s++) begin
            for (int w = 0; w < 2; w++) begin
                m_tag[s][w]    = '0;
                m_valid[s][w]  = 1'b0;
                m_dirty[s][w]  = 1'b0;
                m_recent[s][w] = 1'b0;
                m_line[s][w]   = '0;
            end
        end
        for (int a = 0; a < 65536; a++) begin
            image[a] = word_t'(a) ^ 16'h5a5a;
        end
    endtask

    task automatic check_quiet();
        checks[1]++;
        if (cpu_done !== 1'b0) value_error(1, "cpu_done", 64'(cpu_done), 64'h0);
        if (mem_req.read !== 1'b0) value_error(1, "mem_req.read", 64'(mem_req.read), 64'h0);
        if (mem_req.write !== 1'b0) value_error(1, "mem_req.write", 64'(mem_req.write), 64'h0);
    endtask

    // finish a request on the way that now holds its line
    task automatic apply_access(input logic way);
        int    b;
        line_t l;
        b = readback ? 6 : 2;
        if (rwrite) begin
            image[word_t'(ra)] = rwdata;
            l = m_line[ra.index][way];
            l[int'(ra.offset)*word_bits +: word_bits] = rwdata;
            m_line[ra.index][way]  = l;
            m_dirty[ra.index][way] = 1'b1;
        end else begin
            checks[b]++;
            if (cpu_rdata !== image[word_t'(ra)]) begin
                value_error(b, "cpu_rdata", 64'(cpu_rdata), 64'(image[word_t'(ra)]));
            end
        end
        m_recent[ra.index][way]  = 1'b1;
        m_recent[ra.index][~way] = 1'b0;
        done_count++;
    endtask

    task automatic start_request();
        logic hit0;
        logic hit1;
        ra     = cpu_req.addr;
        rwrite = cpu_req.write;
        rwdata = cpu_req.wdata;
        hit0   = m_valid[ra.index][0] && (m_tag[ra.index][0] == ra.tag);
        hit1   = m_valid[ra.index][1] && (m_tag[ra.index][1] == ra.tag);
        if (hit0 || hit1) begin
            checks[3]++;
            if (cpu_done !== 1'b1) plain_error(3, "a hit was not answered in its first cycle");
            if (mem_req.read !== 1'b0 || mem_req.write !== 1'b0) begin
                plain_error(3, "a hit raised a memory request");
            end
            apply_access(hit1 && !hit0);
        end else begin
            // way 0 is evicted unless it was the last one used
            rvictim   = m_recent[ra.index][0];
            exp_wb    = m_valid[ra.index][rvictim] && m_dirty[ra.index][rvictim];
            wb_addr   = {m_tag[ra.index][rvictim], ra.index, {offset_bits{1'b0}}};
            wb_line   = m_line[ra.index][rvictim];
            fill_addr = {ra.tag, ra.index, {offset_bits{1'b0}}};
            wb_seen   = 0;
            rd_seen   = 0;
            pend      = 1'b1;
            if (cpu_done === 1'b1) begin
                plain_error(exp_wb ? 5 : 4, "a miss was answered without a refill");
            end
        end
    endtask

    task automatic continue_request();
        int b;
        b = exp_wb ? 5 : 4;
        if (mem_req.write && mem_ack) begin
            wb_seen++;
            if (!exp_wb) begin
                plain_error(4, "a write-back was issued for a clean or invalid victim");
            end else begin
                checks[5]++;
                if (mem_req.addr !== wb_addr) begin
                    value_error(5, "mem_req.addr", 64'(mem_req.addr), 64'(wb_addr));
                end
                if (mem_req.wline !== wb_line) begin
                    value_error(5, "mem_req.wline", mem_req.wline, wb_line);
                end
            end
        end
        if (mem_req.read && mem_ready) begin
            rd_seen++;
            checks[b]++;
            if (exp_wb && wb_seen == 0) begin
                plain_error(5, "the refill read came before the write-back was acknowledged");
            end
            if (mem_req.addr !== fill_addr) begin
                value_error(b, "mem_req.addr", 64'(mem_req.addr), 64'(fill_addr));
            end
            if (mem_rline !== image_line(fill_addr)) begin
                value_error(b, "mem_rline", mem_rline, image_line(fill_addr));
            end
        end
        if (cpu_done === 1'b1) begin
            if (rd_seen != 1) begin
                plain_error(b, $sformatf("a miss completed after %0d memory reads", rd_seen));
            end
            if (wb_seen != (exp_wb ? 1 : 0)) begin
                plain_error(b, $sformatf("a miss completed after %0d write-backs", wb_seen));
            end
            m_tag[ra.index][rvictim]   = ra.tag;
            m_valid[ra.index][rvictim] = 1'b1;
            m_dirty[ra.index][rvictim] = 1'b0;
            m_line[ra.index][rvictim]  = image_line(fill_addr);
            apply_access(rvictim);
            pend = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (!reset_n) begin
            reset_edges++;
            pend = 1'b0;
            clear_model();
            // the first reset edge still sees unknown request registers
            if (reset_edges > 1) check_quiet();
        end else if (!started && cpu_valid !== 1'b1) begin
            check_quiet();
        end else begin
            if (!started) begin
                started = 1'b1;
                print_result(1);
            end
            if (pend) begin
                continue_request();
            end else if (cpu_valid === 1'b1) begin
                start_request();
            end else if (cpu_done === 1'b1) begin
                plain_error(3, "cpu_done was raised with no request");
            end
        end

        if (report && !reported) begin
            reported = 1'b1;
            checks[6]++;
            if (pend) plain_error(6, "a request was still outstanding at the end");
            if (done_count != run_count + readback_count) begin
                plain_error(6, $sformatf("%0d requests completed, %0d were sent", done_count,
                            run_count + readback_count));
            end
            for (int b = 2; b <= 6; b++) begin
                print_result(b);
            end
            $display("totals: %0d checks, %0d errors, %0d requests",
                     checks[1] + checks[2] + checks[3] + checks[4] + checks[5] + checks[6],
                     errs[1] + errs[2] + errs[3] + errs[4] + errs[5] + errs[6], done_count);
        end
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top import cache_pkg::*; ();

    localparam int clk_period     = 100;
    localparam int reset_cycles   = 3;
    localparam int run_count      = 2000;
    localparam int tag_count      = 6;
    localparam int readback_count = tag_count * set_count * line_words;
    localparam int max_latency    = 4;
    // a dirty miss needs two memory transactions plus check and refill cycles
    localparam int watchdog_cycles =
        (run_count + readback_count) * (2 * max_latency + 4) + reset_cycles + 10;

    logic     clk       = 1'b0;
    logic     reset_n   = 1'b0;
    logic     cpu_valid = 1'b0;
    cpu_req_t cpu_req   = '0;
    logic     cpu_done;
    word_t    cpu_rdata;
    mem_req_t mem_req;
    line_t    mem_rline = '0;
    logic     mem_ready = 1'b0;
    logic     mem_ack   = 1'b0;

    logic        readback   = 1'b0;
    logic        report     = 1'b0;
    int          error_count;
    logic [31:0] lfsr_state = 32'ha42d;
    int          lat_wb     = 1;
    int          lat_rd     = 1;

    // memory model state
    word_t mem_words [65536];
    logic  mem_busy = 1'b0;
    int    mem_wait = 0;

    always #(clk_period / 2) clk = ~clk;

    cache_top #(
        .set_count (set_count),
        .tag_t     (tag_entry_t),
        .data_t    (line_t)
    ) u_cache_top (
        .clk       (clk),
        .reset_n   (reset_n),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_done  (cpu_done),
        .cpu_rdata (cpu_rdata),
        .mem_req   (mem_req),
        .mem_rline (mem_rline),
        .mem_ready (mem_ready),
        .mem_ack   (mem_ack)
    );

    tb_checker #(
        .run_count      (run_count),
        .readback_count (readback_count)
    ) u_checker (
        .clk         (clk),
        .reset_n     (reset_n),
        .cpu_valid   (cpu_valid),
        .cpu_req     (cpu_req),
        .cpu_done    (cpu_done),
        .cpu_rdata   (cpu_rdata),
        .mem_req     (mem_req),
        .mem_rline   (mem_rline),
        .mem_ready   (mem_ready),
        .mem_ack     (mem_ack),
        .readback    (readback),
        .report      (report),
        .error_count (error_count)
    );

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // six tags over two sets, so the ways keep conflicting
    function automatic logic [tag_bits-1:0] pick_tag(input int i);
        case (i)
            0:       return 13'h0000;
            1:       return 13'h0001;
            2:       return 13'h0abc;
            3:       return 13'h1555;
            4:       return 13'h0f0f;
            default: return 13'h1fff;
        endcase
    endfunction

    // called on a falling edge, returns on a falling edge after cpu_done
    task automatic do_request(input logic write, input word_t addr, input word_t wdata);
        cpu_req.read  = ~write;
        cpu_req.write = write;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_valid     = 1'b1;
        // latencies for the write-back and the refill this request may need
        lat_wb = 1 + int'(take_bits(2));
        lat_rd = 1 + int'(take_bits(2));
        @(posedge clk);
        while (cpu_done !== 1'b1) begin
            @(posedge clk);
        end
        @(negedge clk);
        // sometimes an idle cycle, sometimes back to back
        if (take_bits(1) == 32'd1) begin
            cpu_valid = 1'b0;
            @(negedge clk);
        end
    endtask

    task automatic random_request();
        logic                   write;
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  set_bit;
        logic [offset_bits-1:0] off;
        word_t                  wdata;
        write   = 1'(take_bits(1));
        tag     = pick_tag(int'(take_bits(8)) % tag_count);
        set_bit = index_bits'(take_bits(index_bits));
        off     = offset_bits'(take_bits(offset_bits));
        wdata   = word_t'(take_bits(word_bits));
        do_request(write, {tag, set_bit, off}, wdata);
    endtask

    task automatic serve_memory();
        word_t base;
        base = {mem_req.addr[word_bits-1:offset_bits], {offset_bits{1'b0}}};
        if (mem_req.write) begin
            for (int i = 0; i < line_words; i++) begin
                mem_words[base + word_t'(i)] = mem_req.wline[i*word_bits +: word_bits];
            end
            mem_ack = 1'b1;
        end else begin
            for (int i = 0; i < line_words; i++) begin
                mem_rline[i*word_bits +: word_bits] = mem_words[base + word_t'(i)];
            end
            mem_ready = 1'b1;
        end
    endtask

    // memory answers after lat_wb or lat_rd cycles with a one-cycle pulse
    always @(negedge clk) begin
        mem_ready = 1'b0;
        mem_ack   = 1'b0;
        if (!reset_n) begin
            mem_busy = 1'b0;
            for (int a = 0; a < 65536; a++) begin
                mem_words[a] = word_t'(a) ^ 16'h5a5a;
            end
        end else if (mem_busy) begin
            if (mem_wait > 1) begin
                mem_wait = mem_wait - 1;
            end else begin
                mem_busy = 1'b0;
                serve_memory();
            end
        end else if (mem_req.read || mem_req.write) begin
            mem_busy = 1'b1;
            mem_wait = mem_req.write ? lat_wb : lat_rd;
        end
    end

    initial begin
        repeat (reset_cycles) @(negedge clk);
        reset_n = 1'b1;
        // outputs stay quiet for a couple of cycles before the first request
        repeat (2) @(negedge clk);
        for (int n = 0; n < run_count; n++) begin
            random_request();
        end
        readback = 1'b1;
        for (int t = 0; t < tag_count; t++) begin
            for (int s = 0; s < set_count; s++) begin
                for (int o = 0; o < line_words; o++) begin
                    do_request(1'b0, {pick_tag(t), index_bits'(s), offset_bits'(o)}, 16'h0000);
                end
            end
        end
        cpu_valid = 1'b0;
        report    = 1'b1;
        @(posedge clk);
        @(negedge clk);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog: the run hung, not finished after %0d cycles", watchdog_cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule
